/* Bender.yml */
package:
  name: exec_unit

sources:
  # RTL in compile order
  - files:
      - verilog/rvIsaPkg.sv
      - verilog/execPkg.sv
      - verilog/instrDecoder.sv
      - verilog/largeAlu.sv
      - verilog/resultStage.sv
      - verilog/execUnit.sv

  # Testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/clkGen.sv
      - tests/execUnitTb.sv

/* filelist.f */
+incdir+tests
verilog/rvIsaPkg.sv
verilog/execPkg.sv
verilog/instrDecoder.sv
verilog/largeAlu.sv
verilog/resultStage.sv
verilog/execUnit.sv
tests/clkGen.sv
tests/execUnitTb.sv

/* tests/clkGen.sv */
module clkGen (
  output logic clk,
  output logic rst
);

  localparam int HalfPeriod  = 5;  // 10 time unit period
  localparam int ResetCycles = 16;

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Synchronous reset, dropped on a rising edge
  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* tests/aluRefModel.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
  return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// Expected result of one instruction, straight from the ISA rules
function automatic ExecResultT refExec(input logic [31:0] iw,
                                       input logic [31:0] a,
                                       input logic [31:0] rs2);
  ExecResultT  res;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] b;
  logic [4:0]  sh;
  logic [63:0] prod;
  logic        alt;
  int          sa;
  int          sb;
  opc = iw[6:0];
  f3  = iw[14:12];
  f7  = iw[31:25];
  res = '0;
  b   = (opc == 7'h13) ? {{20{iw[31]}}, iw[31:20]} : rs2; // I-type immediate is sign-extended
  sh  = b[4:0];
  sa  = a;
  sb  = b;
  alt = (opc == 7'h33) ? (f7 == 7'h20) : iw[30];          // sub only in OP, sra in both
  if (opc != 7'h33 && opc != 7'h13) begin
    res.illegal = 1'b1;                                     // Value stays zero
  end else if (opc == 7'h33 && f7 == 7'h01) begin
    case (f3)
      3'd0: begin
        prod = {32'h0, a} * {32'h0, b};
        res.value = prod[31:0];                             // mul
      end
      3'd1: begin
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        res.value = prod[63:32];                            // mulh
      end
      3'd2: begin
        prod = {{32{a[31]}}, a} * {32'h0, b};
        res.value = prod[63:32];                            // mulhsu
      end
      3'd3: begin
        prod = {32'h0, a} * {32'h0, b};
        res.value = prod[63:32];                            // mulhu
      end
      3'd4: begin                                           // div
        if (b == 0)
          res.value = 32'hffff_ffff;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
          res.value = 32'h8000_0000;
        else
          res.value = sa / sb;
      end
      3'd5: res.value = (b == 0) ? 32'hffff_ffff : a / b;  // divu
      3'd6: begin                                           // rem
        if (b == 0)
          res.value = a;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
          res.value = 32'h0;
        else
          res.value = sa % sb;
      end
      default: res.value = (b == 0) ? a : a % b;            // remu
    endcase
  end else begin
    case (f3)
      3'd0: res.value = (opc == 7'h33 && alt) ? a - b : a + b;
      3'd1: res.value = a << sh;
      3'd2: res.value = (sa < sb) ? 32'd1 : 32'd0;
      3'd3: res.value = (a < b) ? 32'd1 : 32'd0;
      3'd4: res.value = a ^ b;
      3'd5: begin
        if (alt)
          res.value = sa >>> sh;                            // Sign fill only for sra
        else
          res.value = a >> sh;
      end
      3'd6: res.value = a | b;
      default: res.value = a & b;
    endcase
  end
  return res;
endfunction

`endif

/* tests/execUnitTb.sv */
module execUnitTb import execPkg::*; ();

  localparam logic [31:0] Seed = 32'ha7b5_3bba;
  localparam int RandomCount = 400;
  localparam int StepLimit   = 1000; // Cycles allowed for one handshake step
  localparam int DrainLimit  = 4000;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } StimT;

  logic        clk;
  logic        rst;
  logic        req;
  logic        ack;
  logic [31:0] instr;
  logic [31:0] rs1Val;
  logic [31:0] rs2Val;
  logic        respReq;
  logic        respAck;
  ExecResultT  resp;

  logic [31:0] lfsrState;
  StimT        stimQ[$];
  int          ackDelay[$];  // Consumer stall per response
  ExecResultT  expQ[$];      // Issue order
  logic [31:0] instrQ[$];
  int          checked     = 0;
  int          valueErrors = 0;
  int          protoErrors = 0;
  int          timeouts    = 0;
  logic        allDone     = 1'b0;
  logic        prevAck     = 1'b0;
  logic        prevReq     = 1'b0; // req as the DUT saw it at the last edge
  logic        prevRespReq = 1'b0;

  `include "aluRefModel.svh"

  clkGen clkGen_i (.clk(clk), .rst(rst));

  execUnit execUnit_i (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .instr(instr), .rs1Val(rs1Val),
    .rs2Val(rs2Val), .respReq(respReq), .respAck(respAck), .resp(resp)
  );

  // One LFSR step per bit taken
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  // Mostly random, a quarter of the time a corner value
  function automatic logic [31:0] pickOperand();
    logic [1:0] sel;
    sel = drawBits(2);
    if (sel != 0)
      return drawBits(32);
    case (drawBits(2))
      0: return 32'h0;
      1: return 32'h8000_0000;
      2: return 32'hffff_ffff;
      default: return 32'h1;
    endcase
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd1, f3, 5'd3, 7'h13};
  endfunction

  task automatic addItem(input logic [31:0] iw, input logic [31:0] a, input logic [31:0] b);
    stimQ.push_back({iw, a, b});
  endtask

  function automatic StimT randomItem();
    StimT        s;
    logic [2:0]  cls;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rs1Idx;
    logic [4:0]  rs2Idx;
    logic [4:0]  rdIdx;
    logic [11:0] imm;
    logic [6:0]  opc;
    cls    = drawBits(3);
    f3     = drawBits(3);
    alt    = drawBits(1);
    rs1Idx = drawBits(5);
    rs2Idx = drawBits(5);
    rdIdx  = drawBits(5);
    imm    = drawBits(12);
    s.rs1  = pickOperand();
    s.rs2  = pickOperand();
    case (cls)
      3'd0, 3'd1, 3'd2: begin // OP, alternate funct7 only for sub and sra
        s.instr = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                   rs2Idx, rs1Idx, f3, rdIdx, 7'h33};
      end
      3'd3, 3'd4: begin       // OP-IMM
        if (f3 == 3'd1)
          imm[11:5] = 7'h00;
        else if (f3 == 3'd5)
          imm[11:5] = alt ? 7'h20 : 7'h00; // srai or srli
        s.instr = {imm, rs1Idx, f3, rdIdx, 7'h13};
      end
      3'd5, 3'd6: s.instr = {7'h01, rs2Idx, rs1Idx, f3, rdIdx, 7'h33}; // M extension
      default: begin          // Anything but OP and OP-IMM
        opc = drawBits(7);
        if (opc == 7'h33 || opc == 7'h13)
          opc = 7'h03;
        s.instr = {imm, rs1Idx, f3, rdIdx, opc};
      end
    endcase
    return s;
  endfunction

  task automatic buildStimulus();
    logic [1:0] sel;
    // Directed corners first
    addItem(encR(7'h00, 3'd0), 32'h7fff_ffff, 32'h1);         // add wrap
    addItem(encR(7'h20, 3'd0), 32'h0, 32'h1);                 // sub
    addItem(encI(12'h400, 3'd0), 32'h10, 32'h0);              // bit 30 set, still addi
    addItem(encR(7'h00, 3'd2), 32'h8000_0000, 32'h1);         // slt
    addItem(encR(7'h00, 3'd3), 32'h8000_0000, 32'h1);         // sltu
    addItem(encI(12'hfff, 3'd3), 32'h5, 32'h0);               // sltiu against all ones
    addItem(encR(7'h20, 3'd5), 32'h8000_0000, 32'd31);        // sra full fill
    addItem(encI({7'h20, 5'd4}, 3'd5), 32'hf000_0000, 32'h0); // srai
    addItem(encI({7'h00, 5'd31}, 3'd1), 32'h1, 32'h0);        // slli
    addItem(encR(7'h01, 3'd0), 32'hffff_ffff, 32'h8000_0000);
    addItem(encR(7'h01, 3'd1), 32'h8000_0000, 32'h8000_0000);
    addItem(encR(7'h01, 3'd2), 32'h8000_0000, 32'hffff_ffff);
    addItem(encR(7'h01, 3'd3), 32'hffff_ffff, 32'hffff_ffff);
    addItem(encR(7'h01, 3'd4), 32'h8000_0000, 32'hffff_ffff); // Signed overflow
    addItem(encR(7'h01, 3'd6), 32'h8000_0000, 32'hffff_ffff);
    addItem(encR(7'h01, 3'd4), 32'h5, 32'h0);                 // Divide by zero
    addItem(encR(7'h01, 3'd5), 32'h5, 32'h0);
    addItem(encR(7'h01, 3'd6), 32'hffff_fff9, 32'h0);
    addItem(encR(7'h01, 3'd7), 32'h7, 32'h0);
    addItem(encR(7'h01, 3'd4), 32'hffff_fff9, 32'h2);         // -7 / 2
    addItem(encR(7'h01, 3'd6), 32'hffff_fff9, 32'h2);
    addItem({25'h0, 7'h63}, 32'h1234_5678, 32'h1);            // Branch opcode, unsupported
    addItem(encI(12'h001, 3'd0), 32'h1234_5678, 32'h0);       // Must still be right
    for (int i = 0; i < RandomCount; i++)
      stimQ.push_back(randomItem());
    // Consumer stalls, one per response
    foreach (stimQ[i]) begin
      sel = drawBits(2);
      ackDelay.push_back(sel == 0 ? int'(drawBits(5)) : 0);
    end
  endtask

  task automatic abortOnTimeout(input string what);
    timeouts++;
    $display("Timeout: %s", what);
    $display("Checked %0d results: %0d value errors, %0d protocol errors, %0d timeouts",
             checked, valueErrors, protoErrors, timeouts);
    $display("TEST FAIL");
    $finish;
  endtask

  // Input four-phase handshake for one instruction
  task automatic issue(input StimT s);
    int cnt;
    expQ.push_back(refExec(s.instr, s.rs1, s.rs2));
    instrQ.push_back(s.instr);
    @(posedge clk);
    req    <= 1'b1;
    instr  <= s.instr;
    rs1Val <= s.rs1;
    rs2Val <= s.rs2;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!ack && cnt < StepLimit);
    if (!ack) begin
      abortOnTimeout("ack never rose for a pending request");
    end else begin
      @(posedge clk);
      req <= 1'b0;
      cnt = 0;
      do begin
        @(negedge clk);
        cnt++;
      end while (ack && cnt < StepLimit);
      if (ack)
        abortOnTimeout("ack stayed high after req fell");
    end
  endtask

  initial begin : driver
    int cnt;
    req       = 1'b0;
    instr     = '0;
    rs1Val    = '0;
    rs2Val    = '0;
    respAck   = 1'b0;
    lfsrState = Seed;
    buildStimulus();
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (rst !== 1'b0 && cnt < StepLimit);
    if (rst !== 1'b0) begin
      abortOnTimeout("reset was never released");
    end else begin
      if (respReq !== 1'b0) begin
        protoErrors++;
        $display("FAIL respReq after reset: got %h expected 0", respReq);
      end
      if (ack !== 1'b0) begin
        protoErrors++;
        $display("FAIL ack after reset: got %h expected 0", ack);
      end
      foreach (stimQ[i])
        issue(stimQ[i]);
      // Drain the pipeline
      cnt = 0;
      while ((expQ.size() != 0 || respReq || respAck) && cnt < DrainLimit) begin
        @(negedge clk);
        cnt++;
      end
      if (expQ.size() != 0 || respReq || respAck) begin
        abortOnTimeout("results still outstanding after the last instruction");
      end else begin
        allDone = 1'b1;
        if (checked != stimQ.size()) begin
          protoErrors++;
          $display("Got %0d results for %0d instructions", checked, stimQ.size());
        end
        $display("Checked %0d results: %0d value errors, %0d protocol errors, %0d timeouts",
                 checked, valueErrors, protoErrors, timeouts);
        if (valueErrors + protoErrors + timeouts == 0)
          $display("TEST PASS");
        else
          $display("TEST FAIL");
        $finish;
      end
    end
  end

  // Output handshake with stalls
  initial begin : responder
    int idx;
    int cnt;
    idx = 0;
    while (!allDone) begin
      @(negedge clk);
      if (rst === 1'b0 && respReq) begin
        repeat (idx < ackDelay.size() ? ackDelay[idx] : 0) @(posedge clk);
        idx++;
        @(posedge clk);
        respAck <= 1'b1;
        cnt = 0;
        do begin
          @(negedge clk);
          cnt++;
        end while (respReq && cnt < StepLimit);
        if (respReq)
          abortOnTimeout("respReq stayed high after respAck");
        @(posedge clk);
        respAck <= 1'b0;
      end
    end
  end

  // Compare on each new response, sampled mid-cycle
  always @(negedge clk) begin : compare
    ExecResultT  exp;
    logic [31:0] sentInstr;
    if (rst === 1'b0) begin
      if (ack && !prevAck && !prevReq) begin // DUT sampled req low at that edge
        protoErrors++;
        $display("ack rose while req was low");
      end
      if (respReq && !prevRespReq) begin
        if (expQ.size() == 0) begin
          protoErrors++;
          $display("A response arrived with no instruction outstanding");
        end else begin
          exp       = expQ.pop_front();
          sentInstr = instrQ.pop_front();
          if (resp.value !== exp.value) begin
            valueErrors++;
            $display("FAIL resp.value instr %h: got %h expected %h",
                     sentInstr, resp.value, exp.value);
          end
          if (resp.illegal !== exp.illegal) begin
            valueErrors++;
            $display("FAIL resp.illegal instr %h: got %h expected %h",
                     sentInstr, resp.illegal, exp.illegal);
          end
          checked++;
        end
      end
    end
    prevAck     = ack;
    prevReq     = req;
    prevRespReq = respReq;
  end

endmodule

/* verilog/execPkg.sv */
package execPkg;
  import rvIsaPkg::*;

  // One load cycle plus this many conditional subtracts per divide
  localparam int DivSteps = 32;

  // Decoder to ALU command, 70 bits
  typedef struct packed {
    logic [Xlen-1:0] operand1; // rs1 value
    logic [Xlen-1:0] operand2; // rs2 value or sign-extended immediate
    Funct3T          funct3;   // Also carries the M function
    logic            qual;     // Subtract or arithmetic shift
    logic            mulDiv;   // M extension operation
    logic            illegal;  // Unsupported opcode
  } AluCmdT;

  // Result as seen by result stage and consumer
  typedef struct packed {
    logic [Xlen-1:0] value;
    logic            illegal; // Value is zero when set
  } ExecResultT;

  // ALU controller
  typedef enum logic [1:0] {
    Idle,   // Waiting for a command
    Single, // First valid cycle of a one-cycle result
    Divide, // Iterating
    Hold    // Result valid, waiting for the result stage
  } AluStateT;

  // Four-phase handshake phases
  typedef enum logic [1:0] {
    ReqWait,   // Return-to-zero done, waiting for a new transfer
    AckHigh,   // Request out, waiting for the acknowledge
    ReqLowWait // Waiting for the other side to drop its signal
  } HsStateT;

endpackage

/* verilog/execUnit.sv */
module execUnit import rvIsaPkg::*, execPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  output logic            ack,
  input  logic [Xlen-1:0] instr,
  input  logic [Xlen-1:0] rs1Val,
  input  logic [Xlen-1:0] rs2Val,
  output logic            respReq,
  input  logic            respAck,
  output ExecResultT      resp
);

  // Decoder to ALU
  AluCmdT cmd;
  logic   cmdValid;
  logic   cmdTaken;

  // ALU to result stage
  ExecResultT result;
  logic       resultValid;
  logic       resultTaken;

  instrDecoder instrDecoder_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .instr    (instr),
    .rs1Val   (rs1Val),
    .rs2Val   (rs2Val),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .cmdTaken (cmdTaken)
  );

  largeAlu largeAlu_i (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .cmdValid    (cmdValid),
    .cmdTaken    (cmdTaken),
    .result      (result),
    .resultValid (resultValid),
    .resultTaken (resultTaken)
  );

  resultStage resultStage_i (
    .clk         (clk),
    .rst         (rst),
    .result      (result),
    .resultValid (resultValid),
    .resultTaken (resultTaken),
    .respReq     (respReq),
    .respAck     (respAck),
    .resp        (resp)
  );

endmodule

/* verilog/instrDecoder.sv */
module instrDecoder import rvIsaPkg::*, execPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,      // Upstream request
  output logic            ack,      // Upstream acknowledge
  input  logic [Xlen-1:0] instr,
  input  logic [Xlen-1:0] rs1Val,
  input  logic [Xlen-1:0] rs2Val,
  output AluCmdT          cmd,
  output logic            cmdValid,
  input  logic            cmdTaken  // ALU started on cmd
);

  HsStateT          hsState;
  OpcodeT           opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [ImmBits-1:0] imm;
  logic             isReg;
  logic             isImm;
  logic             capture;
  AluCmdT           nextCmd;

  // Instruction fields
  assign opcode = OpcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm    = instr[31:20];   // Shift-immediates use the low 5 bits

  assign isReg = (opcode == OpReg);
  assign isImm = (opcode == OpImm);

  // Command formed from the current input word
  always_comb begin
    nextCmd.operand1 = rs1Val;
    nextCmd.operand2 = isImm ? {{(Xlen-ImmBits){imm[ImmBits-1]}}, imm} : rs2Val;
    nextCmd.funct3   = Funct3T'(funct3);
    if (isReg)
      nextCmd.qual = (funct7 == Funct7Alt); // sub, sra
    else
      nextCmd.qual = (Funct3T'(funct3) == Srl) && instr[30]; // srai only, no subi
    nextCmd.mulDiv  = isReg && (funct7 == Funct7Mul);
    nextCmd.illegal = !(isReg || isImm);
  end

  // Take a new word when the register is free or being emptied now
  assign capture = (hsState == ReqWait) && req && (!cmdValid || cmdTaken);

  always_ff @(posedge clk) begin
    if (rst) begin
      hsState  <= ReqWait;
      ack      <= 1'b0;
      cmdValid <= 1'b0;
    end else begin
      if (cmdTaken)
        cmdValid <= 1'b0;
      case (hsState)
        ReqWait: begin
          if (capture) begin
            ack      <= 1'b1;         // Same edge as cmdValid
            cmdValid <= 1'b1;
            hsState  <= ReqLowWait;
          end
        end
        ReqLowWait: begin
          if (!req) begin             // Upstream saw ack
            ack     <= 1'b0;
            hsState <= ReqWait;
          end
        end
        default: hsState <= ReqWait;  // AckHigh unused on the input side
      endcase
    end
  end

  // Command register
  always_ff @(posedge clk) begin
    if (capture)
      cmd <= nextCmd;
  end

endmodule

/* verilog/largeAlu.sv */
module largeAlu import rvIsaPkg::*, execPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  AluCmdT     cmd,
  input  logic       cmdValid,
  output logic       cmdTaken,    // Pulses in the start cycle
  output ExecResultT result,
  output logic       resultValid,
  input  logic       resultTaken
);

  AluStateT aluState;

  logic [Xlen-1:0] op1;
  logic [Xlen-1:0] op2;
  logic [ShamtBits-1:0] shamt;
  MulDivT          mOp;
  logic            startDiv;

  // Adder and shared compare
  logic [Xlen-1:0] sum;
  logic [Xlen:0]   minus;
  logic            lt;
  logic            ltu;

  // Shifter
  logic signed [Xlen:0] shiftIn;
  logic signed [Xlen:0] srFull;

  // Multiplier
  logic                    op1Unsigned;
  logic                    op2Unsigned;
  logic signed [Xlen:0]    op1Ext;
  logic signed [Xlen:0]    op2Ext;
  logic signed [2*Xlen+1:0] product;

  ExecResultT singleResult;
  ExecResultT resultReg;

  // Divider
  logic [Xlen-1:0]       dividend;   // Ends as remainder magnitude
  logic [2*DivSteps-2:0] divisor;    // Shifted right each step
  logic [Xlen-1:0]       quotient;
  logic [DivSteps-1:0]   quotMask;   // Current quotient bit
  logic                  outSign;
  logic                  divRem;     // Remainder wanted
  logic                  divSigned;
  logic [Xlen-1:0]       op1Mag;
  logic [Xlen-1:0]       op2Mag;
  logic                  divFits;
  logic [Xlen-1:0]       dividendNext;
  logic [Xlen-1:0]       quotientNext;
  logic                  divLast;
  ExecResultT            divResult;

  assign op1   = cmd.operand1;
  assign op2   = cmd.operand2;
  assign shamt = op2[ShamtBits-1:0];
  assign mOp   = MulDivT'(cmd.funct3);

  assign startDiv = cmd.mulDiv && !cmd.illegal && (mOp inside {Div, Divu, Rem, Remu});
  assign cmdTaken = (aluState == Idle) && cmdValid;

  // One 33-bit subtract serves sub, slt and sltu
  assign sum   = op1 + op2;
  assign minus = {1'b1, ~op2} + {1'b0, op1} + {{Xlen{1'b0}}, 1'b1};
  assign ltu   = minus[Xlen];                                 // Borrow out
  assign lt    = (op1[Xlen-1] ^ op2[Xlen-1]) ? op1[Xlen-1] : minus[Xlen];

  // Logical right shift is arithmetic with a zero fill bit
  assign shiftIn = {cmd.qual & op1[Xlen-1], op1};
  assign srFull  = shiftIn >>> shamt;

  // Signed 33x33, sign bit chosen by operand signedness
  assign op1Unsigned = (mOp == Mulhu);
  assign op2Unsigned = (mOp == Mulhsu) || (mOp == Mulhu);
  assign op1Ext  = {op1Unsigned ? 1'b0 : op1[Xlen-1], op1};
  assign op2Ext  = {op2Unsigned ? 1'b0 : op2[Xlen-1], op2};
  assign product = op1Ext * op2Ext;

  always_comb begin
    singleResult = '0;
    if (cmd.illegal) begin
      singleResult.illegal = 1'b1;               // Answered with zero
    end else if (cmd.mulDiv) begin
      if (mOp == Mul)
        singleResult.value = product[Xlen-1:0];
      else
        singleResult.value = product[2*Xlen-1:Xlen]; // mulh, mulhsu, mulhu
    end else begin
      case (cmd.funct3)
        Add:  singleResult.value = cmd.qual ? minus[Xlen-1:0] : sum;
        Sll:  singleResult.value = op1 << shamt;
        Slt:  singleResult.value = {{(Xlen-1){1'b0}}, lt};
        Sltu: singleResult.value = {{(Xlen-1){1'b0}}, ltu};
        Xor:  singleResult.value = op1 ^ op2;
        Srl:  singleResult.value = srFull[Xlen-1:0]; // srl, sra
        Or:   singleResult.value = op1 | op2;
        And:  singleResult.value = op1 & op2;
        default: singleResult.value = '0;
      endcase
    end
  end

  // Operand magnitudes for signed divide and remainder
  assign divSigned = (mOp == Div) || (mOp == Rem);
  assign op1Mag = (divSigned && op1[Xlen-1]) ? -op1 : op1;
  assign op2Mag = (divSigned && op2[Xlen-1]) ? -op2 : op2;

  // One restoring step
  assign divFits      = divisor <= {{(2*DivSteps-1-Xlen){1'b0}}, dividend};
  assign dividendNext = divFits ? dividend - divisor[Xlen-1:0] : dividend;
  assign quotientNext = divFits ? quotient | quotMask : quotient;
  assign divLast      = quotMask[0];

  // Zero divisor gives all ones and the dividend back
  // Min by -1 gives 0x80000000 and 0 through the same path
  always_comb begin
    divResult.illegal = 1'b0;
    if (divRem)
      divResult.value = outSign ? -dividendNext : dividendNext;
    else
      divResult.value = outSign ? -quotientNext : quotientNext;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      aluState <= Idle;
    end else begin
      case (aluState)
        Idle:   if (cmdValid) aluState <= startDiv ? Divide : Single;
        Single: aluState <= resultTaken ? Idle : Hold;
        Divide: if (divLast) aluState <= Hold;
        Hold:   if (resultTaken) aluState <= Idle;
        default: aluState <= Idle;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (cmdTaken) begin
      if (startDiv) begin
        dividend <= op1Mag;
        divisor  <= {op2Mag, {(DivSteps-1){1'b0}}};
        quotient <= '0;
        quotMask <= {1'b1, {(DivSteps-1){1'b0}}};
        divRem   <= (mOp == Rem) || (mOp == Remu);
        if (mOp == Div)
          outSign <= (op1[Xlen-1] != op2[Xlen-1]) && |op2; // Keep -1 for x/0
        else
          outSign <= (mOp == Rem) && op1[Xlen-1];          // Remainder follows dividend
      end else begin
        resultReg <= singleResult;
      end
    end else if (aluState == Divide) begin
      dividend <= dividendNext;
      divisor  <= divisor >> 1;
      quotient <= quotientNext;
      quotMask <= quotMask >> 1;
      if (divLast)
        resultReg <= divResult;  // Signed result on the last step
    end
  end

  assign result      = resultReg;
  assign resultValid = (aluState == Single) || (aluState == Hold);

endmodule

/* verilog/resultStage.sv */
module resultStage import execPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ExecResultT result,
  input  logic       resultValid,
  output logic       resultTaken, // Only when empty
  output logic       respReq,
  input  logic       respAck,
  output ExecResultT resp
);

  HsStateT hsState;

  // Holding register is empty only in ReqWait
  assign resultTaken = (hsState == ReqWait) && resultValid;

  always_ff @(posedge clk) begin
    if (rst) begin
      hsState <= ReqWait;
      respReq <= 1'b0;
    end else begin
      case (hsState)
        ReqWait: begin
          if (resultValid) begin
            respReq <= 1'b1;        // Edge after the take cycle
            hsState <= AckHigh;
          end
        end
        AckHigh: begin
          if (respAck) begin        // Consumer has the value
            respReq <= 1'b0;
            hsState <= ReqLowWait;
          end
        end
        ReqLowWait: begin
          // Empty again once the consumer drops ack
          if (!respAck)
            hsState <= ReqWait;
        end
        default: hsState <= ReqWait;
      endcase
    end
  end

  // Held stable while respReq is high
  always_ff @(posedge clk) begin
    if (resultTaken)
      resp <= result;
  end

endmodule

/* verilog/rvIsaPkg.sv */
package rvIsaPkg;

  localparam int Xlen      = 32; // Register width of RV32
  localparam int ImmBits   = 12; // I-type immediate
  localparam int ShamtBits = 5;  // Shift amount field

  // funct7 qualifiers
  localparam logic [6:0] Funct7Alt = 7'b0100000; // sub, sra
  localparam logic [6:0] Funct7Mul = 7'b0000001; // M extension

  // Major opcodes handled here
  // Any other encoding is flagged as unsupported
  typedef enum logic [6:0] {
    OpReg = 7'b0110011, // Register-register
    OpImm = 7'b0010011  // Register-immediate
  } OpcodeT;

  // RV32I arithmetic funct3
  typedef enum logic [2:0] {
    Add  = 3'b000, // add, sub, addi
    Sll  = 3'b001,
    Slt  = 3'b010,
    Sltu = 3'b011,
    Xor  = 3'b100,
    Srl  = 3'b101, // Also sra, qualified by funct7
    Or   = 3'b110,
    And  = 3'b111
  } Funct3T;

  // M extension funct3
  typedef enum logic [2:0] {
    Mul    = 3'b000, // Low half
    Mulh   = 3'b001, // High half, signed x signed
    Mulhsu = 3'b010, // High half, signed x unsigned
    Mulhu  = 3'b011, // High half, unsigned x unsigned
    Div    = 3'b100,
    Divu   = 3'b101,
    Rem    = 3'b110,
    Remu   = 3'b111
  } MulDivT;

endpackage
